// File: design/rdfifo_pkg.sv
/*
 * read fifo shared definitions
 * widths, depths and pointer sizes of the DDR PHY read-data FIFO,
 * together with the capture beat, Wishbone request/response structs
 * and the read-side state encoding
 */

package rdfifo_pkg;

	// one captured DQ beat on the write side
	localparam int BEAT_W = 16;

	// one Wishbone read word is two consecutive beats
	localparam int WORD_W = 2 * BEAT_W;

	// storage is counted in beats on the write side and in words on the read side
	localparam int WR_DEPTH = 16;
	localparam int RD_DEPTH = WR_DEPTH / 2;

	// address bits index the storage, pointers carry one extra wrap bit
	localparam int WR_ADDR_W = $clog2(WR_DEPTH);
	localparam int RD_ADDR_W = $clog2(RD_DEPTH);
	localparam int WR_PTR_W = WR_ADDR_W + 1;
	localparam int RD_PTR_W = RD_ADDR_W + 1;

	// beat handed over by the capture logic, no back-pressure exists
	typedef struct packed
	{
		logic valid;
		logic [BEAT_W-1:0] data;
	} capture_beat_t;

	// Wishbone classic request, read only so there is no we, adr or sel
	typedef struct packed
	{
		logic cyc;
		logic stb;
	} wb_req_t;

	// Wishbone classic response, dat is only meaningful while ack is high
	typedef struct packed
	{
		logic ack;
		logic [WORD_W-1:0] dat;
	} wb_rsp_t;

	// read side response sequence
	// idle waits for a request with a whole word present,
	// fetch drives the word address into the memory,
	// respond presents the registered word with ack
	typedef enum logic [1:0]
	{
		RD_IDLE = 2'd0,
		RD_FETCH = 2'd1,
		RD_RESPOND = 2'd2
	} rd_state_t;

endpackage

// File: design/flop_mem.sv
/*
 * flop memory of the read FIFO
 * written one beat at a time on the write clock, read one word at a
 * time on the read clock through a beat-pair mux and an output register
 */

`timescale 1ns/1ps

module flop_mem
	import rdfifo_pkg::*;
(
	input logic wr_clk,
	input logic wr_en,
	input logic [WR_ADDR_W-1:0] wr_addr,
	input logic [BEAT_W-1:0] wr_data,
	input logic rd_clk,
	input logic rd_en,
	input logic [RD_ADDR_W-1:0] rd_addr,
	output logic [WORD_W-1:0] rd_data
);

	// beat storage, one entry per captured beat
	logic [BEAT_W-1:0] data_stored [WR_DEPTH];

	// all entries side by side, entry 0 in the lowest bits
	logic [BEAT_W*WR_DEPTH-1:0] all_data;

	// word picked by the read address before it is registered
	logic [WORD_W-1:0] mux_word;

	// the write side only ever addresses entries it owns, so a plain
	// enable is enough here
	always_ff @(posedge wr_clk)
	begin
		if (wr_en)
			data_stored[wr_addr] <= wr_data;
	end

	// flatten the array so adjacent beats form one word
	for (genvar entry = 0; entry < WR_DEPTH; entry++)
	begin : g_flatten
		assign all_data[BEAT_W*entry +: BEAT_W] = data_stored[entry];
	end

	// word w holds beats 2w and 2w+1, the earlier beat lands in the low half
	always_comb
	begin
		mux_word = '0;
		for (int w = 0; w < RD_DEPTH; w++)
		begin
			if (rd_addr == w[RD_ADDR_W-1:0])
				mux_word = all_data[WORD_W*w +: WORD_W];
		end
	end

	// output register in the read clock domain, loaded only on a fetch
	always_ff @(posedge rd_clk)
	begin
		if (rd_en)
			rd_data <= mux_word;
	end

endmodule

// File: design/wr_ptr_ctrl.sv
/*
 * write side control of the read FIFO
 * synchronizes reset and the Gray read pointer into the write clock,
 * advances the beat pointer on accepted beats, drops beats while full
 * and keeps a sticky overflow flag
 */

`timescale 1ns/1ps

module wr_ptr_ctrl
	import rdfifo_pkg::*;
(
	input logic wr_clk,
	input logic rst_n,
	input capture_beat_t beat_in,
	input logic [RD_PTR_W-1:0] rd_ptr_gray,
	output logic wr_en,
	output logic [WR_ADDR_W-1:0] wr_addr,
	output logic [WR_PTR_W-1:0] wr_ptr_gray,
	output logic overflow
);

	// reset comes from the read clock domain and is retimed here
	logic [1:0] rst_sync_q;
	logic wr_rst_n;

	// two-flop synchronizer for the Gray read pointer
	logic [RD_PTR_W-1:0] rd_gray_s1;
	logic [RD_PTR_W-1:0] rd_gray_s2;

	// synchronized read pointer in binary, and in beat units
	logic [RD_PTR_W-1:0] rd_ptr_bin;
	logic [WR_PTR_W-1:0] rd_ptr_beats;

	// beat pointer and its next value
	logic [WR_PTR_W-1:0] wr_ptr_bin;
	logic [WR_PTR_W-1:0] wr_ptr_next;
	logic [WR_PTR_W-1:0] fill_beats;
	logic full;

	always_ff @(posedge wr_clk)
	begin
		rst_sync_q <= {rst_sync_q[0], rst_n};
	end

	assign wr_rst_n = rst_sync_q[1];

	// each binary bit is the xor of all Gray bits at and above it
	always_comb
	begin
		for (int i = 0; i < RD_PTR_W; i++)
			rd_ptr_bin[i] = ^(rd_gray_s2 >> i);
	end

	// one word is two beats, so the word pointer doubles into beat units
	assign rd_ptr_beats = {rd_ptr_bin, 1'b0};
	assign fill_beats = wr_ptr_bin - rd_ptr_beats;

	// the read pointer seen here is stale, so space is freed late but never early
	assign full = (fill_beats == WR_PTR_W'(WR_DEPTH));

	// beats arriving while full are simply lost
	assign wr_en = beat_in.valid && !full;
	assign wr_addr = wr_ptr_bin[WR_ADDR_W-1:0];
	assign wr_ptr_next = wr_ptr_bin + WR_PTR_W'(1);

	always_ff @(posedge wr_clk)
	begin
		if (!wr_rst_n)
		begin
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
			wr_ptr_bin <= '0;
			wr_ptr_gray <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			rd_gray_s1 <= rd_ptr_gray;
			rd_gray_s2 <= rd_gray_s1;
			// the Gray copy is registered so only one bit moves per beat
			if (wr_en)
			begin
				wr_ptr_bin <= wr_ptr_next;
				wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
			end
			// sticky until the next reset
			if (beat_in.valid && full)
				overflow <= 1'b1;
		end
	end

endmodule

// File: design/rd_wb_ctrl.sv
/*
 * read side control of the read FIFO
 * synchronizes the Gray beat pointer into the read clock, counts whole
 * words, and serves one word per Wishbone classic read transfer
 */

`timescale 1ns/1ps

module rd_wb_ctrl
	import rdfifo_pkg::*;
(
	input logic rd_clk,
	input logic rst_n,
	input wb_req_t wb_req,
	input logic [WR_PTR_W-1:0] wr_ptr_gray,
	input logic [WORD_W-1:0] mem_data,
	output logic rd_en,
	output logic [RD_ADDR_W-1:0] rd_addr,
	output logic [RD_PTR_W-1:0] rd_ptr_gray,
	output wb_rsp_t wb_rsp
);

	// two-flop synchronizer for the Gray beat pointer
	logic [WR_PTR_W-1:0] wr_gray_s1;
	logic [WR_PTR_W-1:0] wr_gray_s2;

	// synchronized beat pointer in binary
	logic [WR_PTR_W-1:0] wr_ptr_bin;

	// number of whole words written, a lone trailing beat is not counted
	logic [RD_PTR_W-1:0] words_written;

	// word pointer of the read side
	logic [RD_PTR_W-1:0] rd_ptr_bin;
	logic [RD_PTR_W-1:0] rd_ptr_next;

	logic word_avail;
	logic req_valid;

	rd_state_t state;

	always_ff @(posedge rd_clk)
	begin
		if (!rst_n)
		begin
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
		end
		else
		begin
			wr_gray_s1 <= wr_ptr_gray;
			wr_gray_s2 <= wr_gray_s1;
		end
	end

	// Gray to binary, bit i is the xor of Gray bits i and above
	always_comb
	begin
		for (int i = 0; i < WR_PTR_W; i++)
			wr_ptr_bin[i] = ^(wr_gray_s2 >> i);
	end

	// dropping the beat LSB gives the word count, wrap bit included
	assign words_written = wr_ptr_bin[WR_PTR_W-1:1];

	// the write side never runs more than a full memory ahead,
	// so plain inequality means at least one word is waiting
	assign word_avail = (words_written != rd_ptr_bin);

	assign req_valid = wb_req.cyc && wb_req.stb;
	assign rd_ptr_next = rd_ptr_bin + RD_PTR_W'(1);

	// response sequence, the stb sample in idle starts a fixed two cycle path
	// to ack when a word is already there
	always_ff @(posedge rd_clk)
	begin
		if (!rst_n)
		begin
			state <= RD_IDLE;
			rd_ptr_bin <= '0;
			rd_ptr_gray <= '0;
		end
		else
		begin
			case (state)
				RD_IDLE:
				begin
					// without a whole word the request simply waits here
					if (req_valid && word_avail)
						state <= RD_FETCH;
				end
				RD_FETCH:
				begin
					// the memory registers the word on this edge
					state <= RD_RESPOND;
				end
				RD_RESPOND:
				begin
					// the word has been handed over, free its slot
					state <= RD_IDLE;
					rd_ptr_bin <= rd_ptr_next;
					rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
				end
				default:
				begin
					state <= RD_IDLE;
				end
			endcase
		end
	end

	// address and enable only matter during the fetch cycle
	assign rd_en = (state == RD_FETCH);
	assign rd_addr = rd_ptr_bin[RD_ADDR_W-1:0];

	// ack lasts exactly the one respond cycle, dat is the registered word
	always_comb
	begin
		wb_rsp.ack = (state == RD_RESPOND);
		wb_rsp.dat = mem_data;
	end

endmodule

// File: design/read_fifo_top.sv
/*
 * DDR PHY read-data FIFO top level
 * ties the write side control, the flop memory and the Wishbone
 * read side together across the two clock domains
 */

`timescale 1ns/1ps

module read_fifo_top
	import rdfifo_pkg::*;
(
	input logic wr_clk,
	input logic rd_clk,
	input logic rst_n,
	input capture_beat_t beat_in,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output logic overflow
);

	// write port of the memory, owned by the write clock domain
	logic mem_wr_en;
	logic [WR_ADDR_W-1:0] mem_wr_addr;

	// read port of the memory, owned by the read clock domain
	logic mem_rd_en;
	logic [RD_ADDR_W-1:0] mem_rd_addr;
	logic [WORD_W-1:0] mem_rd_data;

	// Gray pointers crossing between the domains
	logic [WR_PTR_W-1:0] wr_ptr_gray;
	logic [RD_PTR_W-1:0] rd_ptr_gray;

	wr_ptr_ctrl u_wr_ptr_ctrl
	(
		.wr_clk (wr_clk),
		.rst_n (rst_n),
		.beat_in (beat_in),
		.rd_ptr_gray (rd_ptr_gray),
		.wr_en (mem_wr_en),
		.wr_addr (mem_wr_addr),
		.wr_ptr_gray (wr_ptr_gray),
		.overflow (overflow)
	);

	// beat payload goes straight into the memory, valid is consumed above
	flop_mem u_flop_mem
	(
		.wr_clk (wr_clk),
		.wr_en (mem_wr_en),
		.wr_addr (mem_wr_addr),
		.wr_data (beat_in.data),
		.rd_clk (rd_clk),
		.rd_en (mem_rd_en),
		.rd_addr (mem_rd_addr),
		.rd_data (mem_rd_data)
	);

	rd_wb_ctrl u_rd_wb_ctrl
	(
		.rd_clk (rd_clk),
		.rst_n (rst_n),
		.wb_req (wb_req),
		.wr_ptr_gray (wr_ptr_gray),
		.mem_data (mem_rd_data),
		.rd_en (mem_rd_en),
		.rd_addr (mem_rd_addr),
		.rd_ptr_gray (rd_ptr_gray),
		.wb_rsp (wb_rsp)
	);

endmodule

// File: verif/tb_read_fifo.sv
/*
 * testbench of the DDR PHY read-data FIFO
 * runs both clocks, drives capture beats and Wishbone classic reads,
 * and checks every word, the read latency and overflow against a beat queue model
 */

`timescale 1ns/1ps

module tb_read_fifo
	import rdfifo_pkg::*;
;

	localparam int RD_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int ACK_LATENCY = 2;
	localparam int RANDOM_BEATS = 64;

	// transfers over all tests: 1 + 1 + 4 + 8 + RANDOM_BEATS/2
	localparam int N_TRANSFERS = 14 + RANDOM_BEATS / 2;
	localparam int WATCHDOG_NS = (N_TRANSFERS * 40 + 2 * RESET_CYCLES) * RD_PERIOD;

	logic rd_clk = 1'b0;
	logic wr_clk = 1'b0;
	logic rst_n;
	capture_beat_t beat_in;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic overflow;

	// model of the FIFO contents, oldest beat at the front
	logic [BEAT_W-1:0] model_q [$];
	logic model_overflow;

	integer seed;
	int test_errors;
	int pass_count;
	int fail_count;

	// scratch for the main sequence and the two random traffic threads
	logic [31:0] rand_val;
	logic [31:0] rd_rand;
	logic [31:0] wr_rand;
	logic [WORD_W-1:0] rd_word;
	bit rd_got;
	int rd_cycles;

	read_fifo_top dut
	(
		.wr_clk (wr_clk),
		.rd_clk (rd_clk),
		.rst_n (rst_n),
		.beat_in (beat_in),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.overflow (overflow)
	);

	// read clock 8 ns, write clock 6 ns, no phase relation intended
	always #4 rd_clk = ~rd_clk;
	always #3 wr_clk = ~wr_clk;

	task automatic report_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
		test_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("error at %0t ns: %s", $time, what);
		test_errors++;
	endtask

	task automatic close_test(input string name);
		if (test_errors == 0)
		begin
			pass_count++;
			$display("%s: ok", name);
		end
		else
		begin
			fail_count++;
			$display("%s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// reset is held for 16 read clocks, then the write side gets time for its own sync
	task automatic apply_reset();
		@(posedge rd_clk);
		#1;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge rd_clk);
		#1;
		rst_n = 1'b1;
		repeat (4) @(posedge rd_clk);
		model_q.delete();
		model_overflow = 1'b0;
	endtask

	// a beat is held for one write clock, the model drops it when 16 beats are unread
	task automatic send_beat(input logic [BEAT_W-1:0] data);
		@(posedge wr_clk);
		#1;
		beat_in.valid = 1'b1;
		beat_in.data = data;
		if (model_q.size() < WR_DEPTH)
			model_q.push_back(data);
		else
			model_overflow = 1'b1;
	endtask

	task automatic wr_idle();
		@(posedge wr_clk);
		#1;
		beat_in.valid = 1'b0;
	endtask

	task automatic start_request();
		@(posedge rd_clk);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
	endtask

	// the master lets go of cyc and stb in the cycle after ack
	task automatic end_request();
		@(posedge rd_clk);
		#1;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	// cycles counts read clock edges, the first one is where stb is sampled
	task automatic wait_ack(input int max_cycles, output bit got,
		output logic [WORD_W-1:0] data, output int cycles);
		got = 1'b0;
		cycles = 0;
		data = '0;
		while (!got && cycles < max_cycles)
		begin
			@(posedge rd_clk);
			#1;
			cycles++;
			if (wb_rsp.ack)
			begin
				got = 1'b1;
				data = wb_rsp.dat;
			end
		end
	endtask

	// the earlier beat of a pair sits in the low half of the word
	task automatic check_word(input logic [WORD_W-1:0] act);
		logic [WORD_W-1:0] exp;
		if (model_q.size() < 2)
		begin
			report_problem("ack arrived while the model holds less than one word");
		end
		else
		begin
			exp = {model_q[1], model_q[0]};
			void'(model_q.pop_front());
			void'(model_q.pop_front());
			if (act !== exp)
				report_value("wb_rsp.dat", exp, act);
		end
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog: the run went on past its time limit of %0d ns", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

	initial
	begin
		seed = 32'h519f0495;
		rst_n = 1'b0;
		beat_in = '0;
		wb_req = '0;
		model_overflow = 1'b0;
		test_errors = 0;
		pass_count = 0;
		fail_count = 0;
		apply_reset();

		// 1: outputs idle after reset, an empty FIFO never answers
		if (wb_rsp.ack !== 1'b0)
			report_value("wb_rsp.ack", 32'd0, 32'(wb_rsp.ack));
		if (overflow !== 1'b0)
			report_value("overflow", 32'd0, 32'(overflow));
		start_request();
		wait_ack(20, rd_got, rd_word, rd_cycles);
		if (rd_got)
			report_problem("ack came back although the FIFO is empty");
		end_request();
		close_test("reset state");

		// 2: a single beat is not a word, the second beat completes it
		rand_val = $random(seed);
		send_beat(rand_val[BEAT_W-1:0]);
		wr_idle();
		start_request();
		wait_ack(20, rd_got, rd_word, rd_cycles);
		if (rd_got)
			report_problem("ack came back with only half a word written");
		rand_val = $random(seed);
		send_beat(rand_val[BEAT_W-1:0]);
		wr_idle();
		wait_ack(20, rd_got, rd_word, rd_cycles);
		if (!rd_got)
			report_problem("no ack after the second beat of the word was written");
		else
			check_word(rd_word);
		end_request();
		close_test("half words");

		// 3: with words already present every read takes the fixed path
		for (int i = 0; i < 8; i++)
		begin
			rand_val = $random(seed);
			send_beat(rand_val[BEAT_W-1:0]);
		end
		wr_idle();
		repeat (10) @(posedge rd_clk);
		for (int i = 0; i < 4; i++)
		begin
			start_request();
			wait_ack(20, rd_got, rd_word, rd_cycles);
			if (!rd_got)
				report_problem("no ack for a word that was written well before");
			else
			begin
				if (rd_cycles != ACK_LATENCY)
					report_value("ack latency", 32'(ACK_LATENCY), 32'(rd_cycles));
				check_word(rd_word);
			end
			end_request();
		end
		close_test("fixed latency");

		// 4: let the read pointer settle on the write side, then overfill
		repeat (10) @(posedge rd_clk);
		for (int i = 0; i < 20; i++)
		begin
			rand_val = $random(seed);
			send_beat(rand_val[BEAT_W-1:0]);
		end
		repeat (4) wr_idle();
		if (overflow !== model_overflow)
			report_value("overflow", 32'(model_overflow), 32'(overflow));
		for (int i = 0; i < 8; i++)
		begin
			start_request();
			wait_ack(20, rd_got, rd_word, rd_cycles);
			if (!rd_got)
				report_problem("no ack while reading back a full FIFO");
			else
				check_word(rd_word);
			end_request();
		end
		close_test("overflow");

		// 5: overflow is sticky, so a fresh reset comes first
		apply_reset();
		fork
			begin
				for (int i = 0; i < RANDOM_BEATS / 2; i++)
				begin
					rd_rand = $random(seed);
					repeat (int'(rd_rand[1:0])) @(posedge rd_clk);
					start_request();
					wait_ack(200, rd_got, rd_word, rd_cycles);
					if (!rd_got)
						report_problem("no ack during random traffic");
					else
						check_word(rd_word);
					end_request();
				end
			end
			begin
				for (int i = 0; i < RANDOM_BEATS; i++)
				begin
					wr_rand = $random(seed);
					repeat (int'(wr_rand[17:16])) wr_idle();
					// keep at most 12 unread beats so the stale pointer never reads full
					while (model_q.size() >= 12)
						wr_idle();
					send_beat(wr_rand[BEAT_W-1:0]);
				end
				wr_idle();
			end
		join
		repeat (4) wr_idle();
		if (overflow !== 1'b0)
			report_value("overflow", 32'd0, 32'(overflow));
		if (model_q.size() != 0)
			report_problem("beats were left unread at the end of random traffic");
		close_test("random traffic");

		$display("summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
		if (fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: list.f
design/rdfifo_pkg.sv
design/flop_mem.sv
design/wr_ptr_ctrl.sv
design/rd_wb_ctrl.sv
design/read_fifo_top.sv
verif/tb_read_fifo.sv

// File: run.sh
#!/usr/bin/env bash
# builds the read FIFO testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_read_fifo -o sim_read_fifo
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

sim_out=$(./obj_dir/sim_read_fifo)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints its verdict on a line of its own
if echo "$sim_out" | grep -qx "test passed"; then
	echo "run.sh: simulation passed"
	exit 0
else
	echo "run.sh: simulation did not pass"
	exit 1
fi
